// ==== source/simt_alu_pkg.sv ====
package simt_alu_pkg;

    localparam int num_threads = 4;
    localparam int num_warps   = 8;
    localparam int nw_bits     = $clog2(num_warps);
    localparam int nr_bits     = 5;
    localparam int nt_bits     = $clog2(num_threads);  // Lane index width

    typedef logic [num_threads-1:0][31:0] lane_data_t;
    typedef logic [num_threads-1:0]       lane_mask_t;

    typedef enum logic [1:0] {
        op_alu,
        op_br,
        op_mul
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic [2:0] {
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu,
        br_jal,
        br_jalr
    } br_op_e;

    typedef enum logic [2:0] {
        mul_mul,
        mul_mulh,
        mul_mulhsu,
        mul_mulhu,
        mul_div,
        mul_divu,
        mul_rem,
        mul_remu
    } mul_op_e;

    typedef struct packed {
        logic [nw_bits-1:0] wid;
        lane_mask_t         tmask;
        logic [31:0]        pc;
        logic [31:0]        next_pc;
        logic [nr_bits-1:0] rd;
        logic               wb;
        op_class_e          op_class;
        alu_op_e            alu_op;     // Valid for op_alu
        br_op_e             br_op;      // Valid for op_br
        mul_op_e            mul_op;     // Valid for op_mul
        logic               use_pc;
        logic               use_imm;
        logic [31:0]        imm;
        logic [nt_bits-1:0] tid;        // Lane that resolves a branch
        lane_data_t         rs1_data;
        lane_data_t         rs2_data;
    } alu_req_t;

    typedef struct packed {
        logic [nw_bits-1:0] wid;
        lane_mask_t         tmask;
        logic [31:0]        pc;
        logic [nr_bits-1:0] rd;
        logic               wb;
    } result_tag_t;

    typedef struct packed {
        result_tag_t tag;
        lane_data_t  data;
    } commit_t;

    typedef struct packed {
        logic [nw_bits-1:0] wid;
        logic               taken;
        logic [31:0]        dest;
    } branch_ctl_t;

endpackage

// ==== source/alu_lane_compute.sv ====
module alu_lane_compute (
    input  simt_alu_pkg::op_class_e  op_class,
    input  simt_alu_pkg::alu_op_e    alu_op,
    input  simt_alu_pkg::br_op_e     br_op,
    input  logic                     use_pc,
    input  logic                     use_imm,
    input  logic [31:0]              pc,
    input  logic [31:0]              imm,
    input  simt_alu_pkg::lane_data_t rs1_data,
    input  simt_alu_pkg::lane_data_t rs2_data,
    output simt_alu_pkg::lane_data_t result,
    output simt_alu_pkg::lane_data_t add_result,
    output simt_alu_pkg::lane_mask_t less,
    output simt_alu_pkg::lane_mask_t equal
);
    import simt_alu_pkg::*;

    logic is_br;
    logic sub_signed;   // Sign extension for compare and arithmetic shift

    assign is_br = (op_class == op_br);

    always_comb begin
        if (is_br) begin
            sub_signed = (br_op == br_lt) || (br_op == br_ge);
        end else begin
            sub_signed = (alu_op == alu_slt) || (alu_op == alu_sra);
        end
    end

    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        logic [31:0] in1_pc;
        logic [31:0] in2_imm;
        logic [31:0] in2_cmp;
        logic [32:0] sub_in1;
        logic [32:0] sub_in2;
        logic [32:0] sub_res;
        logic [32:0] shr_in;
        logic [31:0] shr_res;
        logic [4:0]  shamt;
        logic [31:0] lane_res;

        assign in1_pc  = use_pc ? pc : rs1_data[i];
        assign in2_imm = use_imm ? imm : rs2_data[i];
        // Branches compare rs1 with rs2 even when imm holds the offset
        assign in2_cmp = (use_imm && !is_br) ? imm : rs2_data[i];

        assign add_result[i] = in1_pc + in2_imm;

        assign sub_in1 = {sub_signed & rs1_data[i][31], rs1_data[i]};
        assign sub_in2 = {sub_signed & in2_cmp[31], in2_cmp};
        assign sub_res = sub_in1 - sub_in2;

        assign shamt   = in2_imm[4:0];
        assign shr_in  = {sub_signed & rs1_data[i][31], rs1_data[i]};
        assign shr_res = 32'($signed(shr_in) >>> shamt);

        assign less[i]  = sub_res[32];
        assign equal[i] = ~(|sub_res[31:0]);

        always_comb begin
            case (alu_op)
                alu_add:  lane_res = add_result[i];  // Also lui, auipc
                alu_sub:  lane_res = sub_res[31:0];
                alu_slt,
                alu_sltu: lane_res = {31'b0, sub_res[32]};
                alu_and:  lane_res = rs1_data[i] & in2_imm;
                alu_or:   lane_res = rs1_data[i] | in2_imm;
                alu_xor:  lane_res = rs1_data[i] ^ in2_imm;
                alu_sll:  lane_res = rs1_data[i] << shamt;
                alu_srl,
                alu_sra:  lane_res = shr_res;
                default:  lane_res = add_result[i];
            endcase
        end

        assign result[i] = lane_res;
    end

endmodule

// ==== source/muldiv_unit.sv ====
module muldiv_unit #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  simt_alu_pkg::mul_op_e     mul_op,
    input  simt_alu_pkg::result_tag_t tag_in,
    input  simt_alu_pkg::lane_data_t  in1,
    input  simt_alu_pkg::lane_data_t  in2,
    input  logic                      valid_in,
    output logic                      ready_in,
    output logic                      valid_out,
    input  logic                      ready_out,
    output simt_alu_pkg::result_tag_t tag_out,
    output simt_alu_pkg::lane_data_t  data_out
);
    import simt_alu_pkg::*;

    localparam int div_steps = 32;
    localparam int cnt_bits  = 6;

    logic                busy;
    logic                valid_r;
    logic [cnt_bits-1:0] cnt;
    logic                accept;

    logic sign_a;
    logic sign_b;
    logic is_div_in;
    logic is_rem_in;

    lane_mask_t a_neg;
    lane_mask_t b_neg;
    lane_mask_t q_neg_in;
    lane_data_t abs_a;
    lane_data_t abs_b;
    lane_data_t mul_res;

    // Divider state, one slice per lane
    result_tag_t tag_r;
    lane_data_t  data_r;
    lane_data_t  quo_r;
    lane_data_t  rem_r;
    lane_data_t  dvs_r;
    lane_mask_t  neg_q;
    lane_mask_t  neg_r;
    logic        div_r;
    logic        rem_op_r;

    lane_data_t quo_nxt;
    lane_data_t rem_nxt;
    lane_data_t div_res;

    assign sign_a    = mul_op inside {mul_mulh, mul_mulhsu, mul_div, mul_rem};
    assign sign_b    = mul_op inside {mul_mulh, mul_div, mul_rem};
    assign is_div_in = mul_op inside {mul_div, mul_divu, mul_rem, mul_remu};
    assign is_rem_in = mul_op inside {mul_rem, mul_remu};

    assign ready_in = ~busy;
    assign accept   = valid_in && ready_in;

    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        logic signed [65:0] prod;
        logic        [32:0] trial;
        logic        [32:0] diff;
        logic               fits;

        assign a_neg[i] = sign_a & in1[i][31];
        assign b_neg[i] = sign_b & in2[i][31];
        assign abs_a[i] = a_neg[i] ? -in1[i] : in1[i];
        assign abs_b[i] = b_neg[i] ? -in2[i] : in2[i];
        // A zero divisor keeps the quotient positive, so it stays all ones
        assign q_neg_in[i] = (a_neg[i] ^ b_neg[i]) & (|in2[i]);

        assign prod = $signed({a_neg[i], in1[i]}) * $signed({b_neg[i], in2[i]});
        assign mul_res[i] = (mul_op == mul_mul) ? prod[31:0] : prod[63:32];

        // One restoring step
        assign trial = {rem_r[i], quo_r[i][31]};
        assign diff  = trial - {1'b0, dvs_r[i]};
        assign fits  = (trial >= {1'b0, dvs_r[i]});
        assign rem_nxt[i] = fits ? diff[31:0] : trial[31:0];
        assign quo_nxt[i] = {quo_r[i][30:0], fits};

        // Remainder takes the dividend sign, which also covers divide by zero
        assign div_res[i] = rem_op_r ? (neg_r[i] ? -rem_r[i] : rem_r[i])
                                     : (neg_q[i] ? -quo_r[i] : quo_r[i]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            valid_r <= 1'b0;
            cnt     <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= is_div_in ? cnt_bits'(div_steps) : cnt_bits'(MUL_LATENCY - 1);
        end else if (busy && !valid_r) begin
            if (cnt == '0) begin
                valid_r <= 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (valid_r && ready_out) begin
            valid_r <= 1'b0;
            busy    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_r    <= tag_in;
            div_r    <= is_div_in;
            rem_op_r <= is_rem_in;
            data_r   <= mul_res;  // Product ready now, only delayed
            quo_r    <= abs_a;
            rem_r    <= '0;
            dvs_r    <= abs_b;
            neg_q    <= q_neg_in;
            neg_r    <= a_neg;
        end else if (busy && !valid_r && div_r) begin
            if (cnt != '0) begin
                quo_r <= quo_nxt;
                rem_r <= rem_nxt;
            end else begin
                data_r <= div_res;  // Sign fix-up
            end
        end
    end

    assign valid_out = valid_r;
    assign tag_out   = tag_r;
    assign data_out  = data_r;

endmodule

// ==== source/alu_unit.sv ====
module alu_unit #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  simt_alu_pkg::alu_req_t    req,
    output logic                      commit_valid,
    input  logic                      commit_ready,
    output simt_alu_pkg::commit_t     commit,
    output logic                      branch_valid,
    output simt_alu_pkg::branch_ctl_t branch
);
    import simt_alu_pkg::*;

    lane_data_t alu_result;
    lane_data_t add_result;
    lane_mask_t less;
    lane_mask_t equal;

    logic is_alu_br;
    logic is_mul;
    logic is_jal;

    logic        br_neg;
    logic        br_less;
    logic        br_static;
    logic        br_taken;
    logic [31:0] br_dest;
    logic        is_less;
    logic        is_equal;

    lane_data_t  alu_data;
    result_tag_t req_tag;

    logic        mul_valid_in;
    logic        mul_ready_in;
    logic        mul_valid_out;
    logic        mul_ready_out;
    result_tag_t mul_tag;
    lane_data_t  mul_data;

    logic        stall_in;
    logic        stall_out;
    logic        res_valid;
    logic        res_is_br;
    result_tag_t res_tag;
    lane_data_t  res_data;

    logic        is_br_r;
    branch_ctl_t branch_r;

    assign is_alu_br = (req.op_class == op_br);
    assign is_mul    = (req.op_class == op_mul);

    alu_lane_compute u_lane (
        .op_class   (req.op_class),
        .alu_op     (req.alu_op),
        .br_op      (req.br_op),
        .use_pc     (req.use_pc),
        .use_imm    (req.use_imm),
        .pc         (req.pc),
        .imm        (req.imm),
        .rs1_data   (req.rs1_data),
        .rs2_data   (req.rs2_data),
        .result     (alu_result),
        .add_result (add_result),
        .less       (less),
        .equal      (equal)
    );

    // Branch resolved on lane tid
    assign br_dest  = add_result[req.tid];
    assign is_less  = less[req.tid];
    assign is_equal = equal[req.tid];

    assign br_neg    = req.br_op inside {br_ne, br_ge, br_geu};
    assign br_less   = req.br_op inside {br_lt, br_ge, br_ltu, br_geu};
    assign br_static = req.br_op inside {br_jal, br_jalr};
    assign br_taken  = ((br_less ? is_less : is_equal) ^ br_neg) | br_static;

    assign is_jal   = is_alu_br && br_static;
    assign alu_data = is_jal ? {num_threads{req.next_pc}} : alu_result;  // Link address

    assign req_tag = '{
        wid:   req.wid,
        tmask: req.tmask,
        pc:    req.pc,
        rd:    req.rd,
        wb:    req.wb
    };

    // Never accept into muldiv while the top refuses the request
    assign mul_valid_in  = req_valid && is_mul && !stall_out;
    assign mul_ready_out = ~stall_out;

    muldiv_unit #(
        .MUL_LATENCY (MUL_LATENCY)
    ) u_muldiv (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_op    (req.mul_op),
        .tag_in    (req_tag),
        .in1       (req.rs1_data),
        .in2       (req.rs2_data),
        .valid_in  (mul_valid_in),
        .ready_in  (mul_ready_in),
        .valid_out (mul_valid_out),
        .ready_out (mul_ready_out),
        .tag_out   (mul_tag),
        .data_out  (mul_data)
    );

    assign stall_out = commit_valid && !commit_ready;
    // A finished muldiv result goes ahead of any newer ALU request
    assign stall_in  = stall_out || (is_mul ? !mul_ready_in : mul_valid_out);
    assign req_ready = ~stall_in;

    assign res_valid = mul_valid_out || (req_valid && !is_mul);
    assign res_tag   = mul_valid_out ? mul_tag : req_tag;
    assign res_data  = mul_valid_out ? mul_data : alu_data;
    assign res_is_br = !mul_valid_out && is_alu_br;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else if (!stall_out) begin
            commit_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_out) begin
            commit.tag     <= res_tag;
            commit.data    <= res_data;
            is_br_r        <= res_is_br;
            branch_r.wid   <= res_tag.wid;
            branch_r.taken <= br_taken;
            branch_r.dest  <= br_dest;
        end
    end

    assign branch_valid = commit_valid && commit_ready && is_br_r;  // Strobe on handshake
    assign branch       = branch_r;

endmodule

// ==== testbench/alu_unit_assert.sv ====
module alu_unit_check (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      req_valid,
    input logic                      req_ready,
    input simt_alu_pkg::alu_req_t    req,
    input logic                      commit_valid,
    input logic                      commit_ready,
    input simt_alu_pkg::commit_t     commit,
    input logic                      branch_valid,
    input simt_alu_pkg::branch_ctl_t branch,
    input logic                      mul_valid_out,
    input logic                      mul_ready_out
);
    timeunit 1ns;
    timeprecision 1ps;
    import simt_alu_pkg::*;

    logic [9:0]  fail_bits;  // One bit per assertion
    logic        acc;
    int          n_acc;
    int          n_commit;
    lane_data_t  exp_data_r;
    lane_data_t  mul_exp_r;
    result_tag_t exp_tag_r;
    logic        chk_data_r;
    logic        exp_br_r;
    logic        exp_taken_r;
    logic [31:0] exp_dest_r;

    initial fail_bits = '0;

    function automatic lane_data_t alu_model(input alu_req_t r);
        lane_data_t  d;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        for (int i = 0; i < num_threads; i++) begin
            a = r.rs1_data[i];
            b = r.use_imm ? r.imm : r.rs2_data[i];
            p = r.use_pc ? r.pc : a;
            case (r.alu_op)
                alu_sub:  d[i] = a - b;
                alu_slt:  d[i] = {31'b0, $signed(a) < $signed(b)};
                alu_sltu: d[i] = {31'b0, a < b};
                alu_and:  d[i] = a & b;
                alu_or:   d[i] = a | b;
                alu_xor:  d[i] = a ^ b;
                alu_sll:  d[i] = a << b[4:0];
                alu_srl:  d[i] = a >> b[4:0];
                alu_sra:  d[i] = $signed(a) >>> b[4:0];
                default:  d[i] = p + b;
            endcase
            if (r.op_class == op_br) d[i] = r.next_pc;  // Link value checked only for jumps
        end
        return d;
    endfunction

    function automatic logic br_model(input alu_req_t r);
        logic [31:0] a;
        logic [31:0] b;
        a = r.rs1_data[r.tid];
        b = r.rs2_data[r.tid];
        case (r.br_op)
            br_eq:   return a == b;
            br_ne:   return a != b;
            br_lt:   return $signed(a) < $signed(b);
            br_ge:   return $signed(a) >= $signed(b);
            br_ltu:  return a < b;
            br_geu:  return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic lane_data_t muldiv_model(input alu_req_t r);
        lane_data_t         d;
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        sq;
        logic [31:0]        sr;
        logic [31:0]        uq;
        logic [31:0]        ur;
        logic signed [63:0] p;
        logic               zero;
        logic               ovf;
        for (int i = 0; i < num_threads; i++) begin
            a    = r.rs1_data[i];
            b    = r.rs2_data[i];
            sa   = a;
            sb   = b;
            zero = (b == 0);
            ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
            case (r.mul_op)
                mul_mul:    p = {32'b0, a} * {32'b0, b};
                mul_mulh:   p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                mul_mulhsu: p = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
                default:    p = {32'b0, a} * {32'b0, b};
            endcase
            if (zero) begin
                sq = '1;
                sr = a;
                uq = '1;
                ur = a;
            end else begin
                uq = a / b;
                ur = a % b;
                if (ovf) begin
                    sq = a;
                    sr = '0;
                end else begin
                    sq = sa / sb;
                    sr = sa % sb;
                end
            end
            case (r.mul_op)
                mul_mul:  d[i] = p[31:0];
                mul_div:  d[i] = sq;
                mul_divu: d[i] = uq;
                mul_rem:  d[i] = sr;
                mul_remu: d[i] = ur;
                default:  d[i] = p[63:32];
            endcase
        end
        return d;
    endfunction

    assign acc = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (acc && req.op_class != op_mul) begin
            exp_data_r  <= alu_model(req);
            exp_tag_r   <= '{req.wid, req.tmask, req.pc, req.rd, req.wb};
            chk_data_r  <= (req.op_class == op_alu) || (req.br_op inside {br_jal, br_jalr});
            exp_taken_r <= br_model(req);
            exp_dest_r  <= (req.use_pc ? req.pc : req.rs1_data[req.tid])
                           + (req.use_imm ? req.imm : req.rs2_data[req.tid]);
        end
        if (acc && req.op_class == op_mul) begin
            mul_exp_r <= muldiv_model(req);
        end
    end

    always_ff @(posedge clk) begin
        if (!(commit_valid && !commit_ready)) begin
            exp_br_r <= acc && (req.op_class == op_br);  // Commit register loads
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            n_acc    <= 0;
            n_commit <= 0;
        end else begin
            if (acc) begin
                n_acc <= n_acc + 1;
            end
            if (commit_valid && commit_ready) begin
                n_commit <= n_commit + 1;
            end
        end
    end

    a_reset: assert property (@(posedge clk) !rst_n |=> !commit_valid)
        else begin fail_bits[0] = 1'b1; $error("commit_valid is high right after reset"); end

    a_alu_data: assert property (@(posedge clk) disable iff (!rst_n)
        acc && req.op_class != op_mul |=> commit_valid && (!chk_data_r || commit.data == exp_data_r))
        else begin
            fail_bits[1] = 1'b1;
            $error("FAILED alu_data expected %h actual %h",
                   $sampled(exp_data_r), $sampled(commit.data));
        end

    a_alu_tag: assert property (@(posedge clk) disable iff (!rst_n)
        acc && req.op_class != op_mul |=> commit.tag == exp_tag_r)
        else begin
            fail_bits[2] = 1'b1;
            $error("FAILED alu_tag expected %h actual %h",
                   $sampled(exp_tag_r), $sampled(commit.tag));
        end

    a_branch: assert property (@(posedge clk) disable iff (!rst_n)
        acc && req.op_class == op_br |=> branch.taken == exp_taken_r && branch.dest == exp_dest_r
                                         && branch.wid == exp_tag_r.wid)
        else begin
            fail_bits[3] = 1'b1;
            $error("FAILED branch expected %h %b %h actual %h %b %h",
                   $sampled(exp_tag_r.wid), $sampled(exp_taken_r), $sampled(exp_dest_r),
                   $sampled(branch.wid), $sampled(branch.taken), $sampled(branch.dest));
        end

    a_muldiv: assert property (@(posedge clk) disable iff (!rst_n)
        mul_valid_out && mul_ready_out |=> commit_valid && commit.tag.rd == 5'd31
                                            && commit.data == mul_exp_r)
        else begin
            fail_bits[4] = 1'b1;
            $error("FAILED muldiv expected %h actual %h",
                   $sampled(mul_exp_r), $sampled(commit.data));
        end

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        mul_valid_out && req_valid && req.op_class != op_mul |-> !req_ready)
        else begin fail_bits[5] = 1'b1; $error("ALU request accepted ahead of a muldiv result"); end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |-> !req_ready ##1 commit_valid && $stable(commit)
                                          && $stable(branch))
        else begin fail_bits[6] = 1'b1; $error("Commit or request side moved during a stall"); end

    a_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        branch_valid == (commit_valid && commit_ready && exp_br_r))
        else begin
            fail_bits[7] = 1'b1;
            $error("branch_valid does not match the commit handshake of a branch");
        end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        n_acc == 0 |-> !commit_valid && !branch_valid)
        else begin fail_bits[8] = 1'b1; $error("Commit side active before any request"); end

    a_once: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> n_commit < n_acc)
        else begin fail_bits[9] = 1'b1; $error("Commit without a matching accepted request"); end

endmodule

bind alu_unit alu_unit_check chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .commit_valid  (commit_valid),
    .commit_ready  (commit_ready),
    .commit        (commit),
    .branch_valid  (branch_valid),
    .branch        (branch),
    .mul_valid_out (mul_valid_out),
    .mul_ready_out (mul_ready_out)
);

// ==== testbench/alu_unit_tb.sv ====
module alu_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import simt_alu_pkg::*;

    localparam int num_ops  = 600;
    localparam int clk_half = 20;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    alu_req_t    req;
    logic        commit_valid;
    logic        commit_ready;
    commit_t     commit;
    logic        branch_valid;
    branch_ctl_t branch;
    int          seed;
    alu_req_t    next_req;

    alu_unit #(
        .MUL_LATENCY (3)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .branch_valid (branch_valid),
        .branch       (branch)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // Ops cycle through every opcode of each class
    function automatic alu_req_t make_req(input int n);
        alu_req_t    r;
        logic [31:0] v;
        v          = $random(seed);
        r          = '0;
        r.wid      = v[2:0];
        r.tmask    = v[6:3];
        r.wb       = v[7];
        r.use_pc   = v[8];
        r.use_imm  = v[9];
        r.tid      = v[11:10];
        r.pc       = $random(seed);
        r.next_pc  = r.pc + 4;
        r.imm      = $random(seed);
        r.rd       = 5'(v[31:16] % 31);
        r.op_class = op_class_e'(n % 3);
        r.alu_op   = alu_op_e'((n / 3) % 10);
        r.br_op    = br_op_e'((n / 3) % 8);
        r.mul_op   = mul_op_e'((n / 3) % 8);
        for (int i = 0; i < num_threads; i++) begin
            r.rs1_data[i] = $random(seed);
            r.rs2_data[i] = $random(seed);
        end
        if (r.op_class == op_br && v[12]) r.rs2_data = r.rs1_data;  // Equal operands
        if (r.op_class == op_mul) begin
            r.rd = 5'd31;
            if (v[13]) begin  // Divide by zero and overflow corners
                r.rs2_data[0] = '0;
                r.rs1_data[1] = 32'h8000_0000;
                r.rs2_data[1] = 32'hffff_ffff;
            end
        end
        return r;
    endfunction

    task automatic send(input alu_req_t r);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    always @(posedge clk) begin
        commit_ready <= ($random(seed) & 3) != 0;  // Stalls about a quarter of the time
    end

    always @(negedge clk) begin
        if (dut.chk.fail_bits != '0) begin
            $display("STATUS: FAIL");
            $fatal(1, "Assertion failure, see error above");
        end
    end

    initial begin
        #(num_ops * 40 * 2 * clk_half);
        $display("STATUS: FAIL");
        $fatal(1, "Timeout: operations did not complete in time");
    end

    initial begin
        seed         = 26538;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        commit_ready = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        for (int n = 0; n < num_ops; n++) begin
            @(negedge clk);
            next_req = make_req(n);
            send(next_req);
        end
        @(negedge clk);
        while (dut.u_muldiv.busy || commit_valid) @(negedge clk);
        @(negedge clk);
        if (dut.chk.fail_bits != '0) begin
            $display("STATUS: FAIL");
            $fatal(1, "Assertion failure at end of run");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== alu_unit.f ====
source/simt_alu_pkg.sv
source/alu_lane_compute.sv
source/muldiv_unit.sv
source/alu_unit.sv
testbench/alu_unit_assert.sv
testbench/alu_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f alu_unit.f --top-module alu_unit_tb -o alu_unit_sim &&
./obj_dir/alu_unit_sim +verilator+error+limit+100 ||
{ echo "simulation failed"; exit 1; }
